// ==== tb.f ====
+incdir+source
source/vcfg_io_pkg.sv
source/vcfg_video_pkg.sv
source/host_cmd_regs.sv
source/umuldiv.sv
source/scaler_window_calc.sv
source/video_cfg_top.sv
sim/video_cfg_properties.sv
sim/tb_video_cfg.sv

// ==== sim/tb_video_cfg.sv ====
`timescale 1ns/10ps
`include "vcfg_defines.svh"

module tb_video_cfg;

	logic                   clk_sys;
	logic                   resetd;
	logic                   io_uio;
	logic                   io_strobe;
	vcfg_io_pkg::io_word_t  io_din;
	vcfg_video_pkg::ar_t    arx;
	vcfg_video_pkg::ar_t    ary;
	vcfg_video_pkg::coord_t htotal;
	vcfg_video_pkg::coord_t vtotal;
	logic                   hs_neg;
	logic                   vs_neg;
	vcfg_video_pkg::coord_t out_w;
	vcfg_video_pkg::coord_t out_h;
	vcfg_video_pkg::coord_t hmin;
	vcfg_video_pkg::coord_t hmax;
	vcfg_video_pkg::coord_t vmin;
	vcfg_video_pkg::coord_t vmax;
	logic                   win_update;

	int                     seed;
	vcfg_io_pkg::io_word_t  words[$];

	// Reference copy of the host registers
	vcfg_video_pkg::coord_t m_width;
	vcfg_video_pkg::coord_t m_hfp;
	vcfg_video_pkg::coord_t m_hs;
	vcfg_video_pkg::coord_t m_hbp;
	vcfg_video_pkg::coord_t m_height;
	vcfg_video_pkg::coord_t m_vfp;
	vcfg_video_pkg::coord_t m_vs;
	vcfg_video_pkg::coord_t m_vbp;
	logic                   m_hs_neg;
	logic                   m_vs_neg;
	vcfg_video_pkg::coord_t m_vset;
	vcfg_video_pkg::coord_t m_hset;
	logic                   m_freescale;
	vcfg_video_pkg::ar_t    m_arc[4];

	video_cfg_top u_dut (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_uio(io_uio), .i_io_strobe(io_strobe), .i_io_din(io_din),
		.i_arx(arx), .i_ary(ary),
		.o_htotal(htotal), .o_vtotal(vtotal), .o_hs_neg(hs_neg), .o_vs_neg(vs_neg),
		.o_out_w(out_w), .o_out_h(out_h),
		.o_hmin(hmin), .o_hmax(hmax), .o_vmin(vmin), .o_vmax(vmax),
		.o_win_update(win_update)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_coord(input string name, input vcfg_video_pkg::coord_t exp,
		input vcfg_video_pkg::coord_t act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic int rnd_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Low 12 bits carry the value, top nibble is noise
	function automatic vcfg_io_pkg::io_word_t noisy_word(input int lo, input int hi);
		return {4'($random(seed)), 12'(rnd_range(lo, hi))};
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic void model_frame(input logic [7:0] cmd);
		foreach (words[i]) begin
			if (cmd == `VCFG_CMD_TIMING) begin
				case (i)
					0: m_width = words[i][11:0];
					1: m_hfp = words[i][11:0];
					2: begin
						m_hs     = words[i][11:0];
						m_hs_neg = words[i][15];
					end
					3: m_hbp = words[i][11:0];
					4: m_height = words[i][11:0];
					5: m_vfp = words[i][11:0];
					6: begin
						m_vs     = words[i][11:0];
						m_vs_neg = words[i][15];
					end
					7: m_vbp = words[i][11:0];
					default: ;
				endcase
			end else if (cmd == `VCFG_CMD_VSET && i == 0) begin
				m_vset = words[i][11:0];
			end else if (cmd == `VCFG_CMD_HSET && i == 0) begin
				m_freescale = words[i][15];
				m_hset      = words[i][11:0];
			end else if (cmd == `VCFG_CMD_ARC && i < 4) begin
				m_arc[i] = words[i][12:0];
			end
		end
	endfunction

	function automatic vcfg_video_pkg::coord_t out_size(input vcfg_video_pkg::coord_t set,
		input vcfg_video_pkg::coord_t full);
		return (set != '0 && set < full) ? set : full;
	endfunction

	task automatic check_state();
		vcfg_video_pkg::ar_t    sel_x;
		vcfg_video_pkg::ar_t    sel_y;
		vcfg_video_pkg::coord_t ow;
		vcfg_video_pkg::coord_t oh;
		vcfg_video_pkg::coord_t rx;
		vcfg_video_pkg::coord_t ry;
		vcfg_video_pkg::coord_t w;
		vcfg_video_pkg::coord_t h;
		vcfg_video_pkg::coord_t x0;
		vcfg_video_pkg::coord_t y0;
		logic                   direct;
		logic [23:0]            num;
		check_coord("o_htotal", m_width + m_hfp + m_hbp + m_hs, htotal);
		check_coord("o_vtotal", m_height + m_vfp + m_vbp + m_vs, vtotal);
		check_flag("o_hs_neg", m_hs_neg, hs_neg);
		check_flag("o_vs_neg", m_vs_neg, vs_neg);
		ow = out_size(m_hset, m_width);
		oh = out_size(m_vset, m_height);
		check_coord("o_out_w", ow, out_w);
		check_coord("o_out_h", oh, out_h);
		// Ratio selection
		sel_x = arx;
		sel_y = ary;
		if (ary == '0) begin
			sel_x = (arx == 13'd1) ? m_arc[0] : (arx == 13'd2) ? m_arc[2] : '0;
			sel_y = (arx == 13'd1) ? m_arc[1] : (arx == 13'd2) ? m_arc[3] : '0;
		end
		direct = sel_x[12] | sel_y[12];
		rx = sel_x[11:0];
		ry = sel_y[11:0];
		// Window size, then clip and centre
		if (m_freescale || rx == '0 || ry == '0) begin
			w = ow;
			h = oh;
		end else if (direct) begin
			w = rx;
			h = ry;
		end else begin
			num = oh * rx;
			w = vcfg_video_pkg::coord_t'(num / ry);
			num = ow * ry;
			h = vcfg_video_pkg::coord_t'(num / rx);
		end
		if (w > ow)
			w = ow;
		if (h > oh)
			h = oh;
		x0 = (m_width - w) >> 1;
		y0 = (m_height - h) >> 1;
		check_coord("o_hmin", x0, hmin);
		check_coord("o_hmax", x0 + w - 1, hmax);
		check_coord("o_vmin", y0, vmin);
		check_coord("o_vmax", y0 + h - 1, vmax);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic strobe_word(input vcfg_io_pkg::io_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		next_cycle();
		io_strobe = 1'b0;
		repeat (rnd_range(1, 2)) next_cycle();
	endtask

	task automatic send_frame(input logic [7:0] cmd);
		io_uio = 1'b1;
		next_cycle();
		strobe_word({8'($random(seed)), cmd});
		foreach (words[i]) strobe_word(words[i]);
		io_uio = 1'b0;
		next_cycle();
		model_frame(cmd);
	endtask

	task automatic send_timing();
		words.delete();
		words.push_back(noisy_word(64, 2047));
		words.push_back(noisy_word(1, 200));
		words.push_back(noisy_word(1, 100));
		words.push_back(noisy_word(1, 300));
		words.push_back(noisy_word(64, 2047));
		words.push_back(noisy_word(1, 20));
		words.push_back(noisy_word(1, 10));
		words.push_back(noisy_word(1, 60));
		// Extra words past the eight timing fields
		repeat (rnd_range(0, 2)) words.push_back(16'($random(seed)));
		send_frame(`VCFG_CMD_TIMING);
	endtask

	task automatic send_size(input logic [7:0] cmd);
		words.delete();
		if (rnd_range(0, 3) == 0)
			words.push_back({4'($random(seed)), 12'd0});
		else
			words.push_back(noisy_word(32, 4095));
		send_frame(cmd);
	endtask

	task automatic send_arc();
		int kind;
		words.delete();
		repeat (4) begin
			kind = rnd_range(0, 3);
			if (kind == 0)
				words.push_back({3'($random(seed)), 13'h1000 | 13'(rnd_range(1, 4095))});
			else if (kind == 1)
				words.push_back({3'($random(seed)), 13'd0});
			else
				words.push_back({3'($random(seed)), 13'(rnd_range(32, 63))});
		end
		send_frame(`VCFG_CMD_ARC);
	endtask

	task automatic wait_updates(input int n, input string what);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < n) begin
			next_cycle();
			cycles++;
			if (win_update === 1'b1)
				seen++;
			if (cycles > 1000) begin
				$display("Window update never came while waiting after %s", what);
				abort_run();
			end
		end
	endtask

	task automatic settle_check(input string what);
		repeat (2) next_cycle();
		wait_updates(2, what);
		check_state();
	endtask

	initial begin
		seed        = 15;
		resetd      = 1'b1;
		io_uio      = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		arx         = '0;
		ary         = '0;
		m_width     = `VCFG_DEF_WIDTH;
		m_hfp       = `VCFG_DEF_HFP;
		m_hs        = `VCFG_DEF_HS;
		m_hbp       = `VCFG_DEF_HBP;
		m_height    = `VCFG_DEF_HEIGHT;
		m_vfp       = `VCFG_DEF_VFP;
		m_vs        = `VCFG_DEF_VS;
		m_vbp       = `VCFG_DEF_VBP;
		m_hs_neg    = 1'b0;
		m_vs_neg    = 1'b0;
		m_vset      = '0;
		m_hset      = '0;
		m_freescale = 1'b0;
		foreach (m_arc[i]) m_arc[i] = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		resetd = 1'b0;

		// 1080p defaults
		wait_updates(2, "reset");
		check_coord("o_htotal", 12'd2204, htotal);
		check_coord("o_vtotal", 12'd1125, vtotal);
		check_coord("o_hmax", 12'd1919, hmax);
		check_coord("o_vmax", 12'd1079, vmax);
		check_state();

		repeat (10) begin
			send_timing();
			settle_check("a timing frame");
		end

		// Ratios through the multiply-divide unit
		repeat (10) begin
			arx = vcfg_video_pkg::ar_t'(rnd_range(32, 63));
			ary = vcfg_video_pkg::ar_t'(rnd_range(32, 63));
			settle_check("a new aspect ratio");
		end

		repeat (8) begin
			arx = 13'h1000 | vcfg_video_pkg::ar_t'(rnd_range(1, 4095));
			ary = vcfg_video_pkg::ar_t'(rnd_range(1, 8191));
			settle_check("a direct size");
		end

		// Output size, freescale and custom ratios, mixed with timing
		ary = '0;
		repeat (24) begin
			case (rnd_range(0, 4))
				0: send_size(`VCFG_CMD_VSET);
				1: send_size(`VCFG_CMD_HSET);
				2: send_arc();
				3: send_timing();
				default: arx = vcfg_video_pkg::ar_t'(rnd_range(0, 3));
			endcase
			settle_check("a size or custom ratio change");
		end

		// Nothing may change from here
		repeat (6) begin
			repeat (rnd_range(1, 5)) strobe_word(16'($random(seed)));
			settle_check("strobes outside a frame");
			words.delete();
			repeat (rnd_range(1, 10)) words.push_back(16'($random(seed)));
			send_frame(8'h40 + 8'(rnd_range(0, 63)));
			settle_check("an unknown command");
		end

		if (u_dut.u_props.n_fail != 0) begin
			$display("Bound assertions reported %0d failures", u_dut.u_props.n_fail);
			abort_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// ==== sim/video_cfg_properties.sv ====
`timescale 1ns/10ps

module video_cfg_properties (
	input logic                   clk_sys,
	input logic                   resetd,
	input logic                   i_win_update,
	input vcfg_video_pkg::coord_t i_hmin,
	input vcfg_video_pkg::coord_t i_hmax,
	input vcfg_video_pkg::coord_t i_vmin,
	input vcfg_video_pkg::coord_t i_vmax
);

	int n_fail;

	initial n_fail = 0;

	// One pulse per finished window loop
	a_single_pulse: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_win_update |=> !i_win_update
	) else begin
		n_fail++;
		$error("o_win_update high for two cycles in a row");
	end

	a_window_order: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_win_update |-> (i_hmin <= i_hmax && i_vmin <= i_vmax)
	) else begin
		n_fail++;
		$error("Window written with min above max");
	end

	// First reset edge clears the pulse
	a_quiet_in_reset: assert property (
		@(posedge clk_sys) resetd ##1 resetd |-> !i_win_update
	) else begin
		n_fail++;
		$error("o_win_update high during reset");
	end

endmodule

bind video_cfg_top video_cfg_properties u_props (
	.clk_sys      (clk_sys),
	.resetd       (resetd),
	.i_win_update (o_win_update),
	.i_hmin       (o_hmin),
	.i_hmax       (o_hmax),
	.i_vmin       (o_vmin),
	.i_vmax       (o_vmax)
);

// ==== source/video_cfg_top.sv ====
`timescale 1ns/10ps

module video_cfg_top (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_uio,
	input  logic                   i_io_strobe,
	input  vcfg_io_pkg::io_word_t  i_io_din,
	input  vcfg_video_pkg::ar_t    i_arx,
	input  vcfg_video_pkg::ar_t    i_ary,
	output vcfg_video_pkg::coord_t o_htotal,
	output vcfg_video_pkg::coord_t o_vtotal,
	output logic                   o_hs_neg,
	output logic                   o_vs_neg,
	output vcfg_video_pkg::coord_t o_out_w,
	output vcfg_video_pkg::coord_t o_out_h,
	output vcfg_video_pkg::coord_t o_hmin,
	output vcfg_video_pkg::coord_t o_hmax,
	output vcfg_video_pkg::coord_t o_vmin,
	output vcfg_video_pkg::coord_t o_vmax,
	output logic                   o_win_update
);

	vcfg_video_pkg::coord_t width;
	vcfg_video_pkg::coord_t height;
	vcfg_video_pkg::coord_t vset;
	vcfg_video_pkg::coord_t hset;
	logic                   freescale;
	vcfg_video_pkg::ar_t    arc1x;
	vcfg_video_pkg::ar_t    arc1y;
	vcfg_video_pkg::ar_t    arc2x;
	vcfg_video_pkg::ar_t    arc2y;

	// Host side registers
	host_cmd_regs u_cmd (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_uio(i_io_uio), .i_io_strobe(i_io_strobe), .i_io_din(i_io_din),
		.o_width(width), .o_height(height), .o_vset(vset), .o_hset(hset),
		.o_freescale(freescale),
		.o_arc1x(arc1x), .o_arc1y(arc1y), .o_arc2x(arc2x), .o_arc2y(arc2y),
		.o_htotal(o_htotal), .o_vtotal(o_vtotal),
		.o_hs_neg(o_hs_neg), .o_vs_neg(o_vs_neg)
	);

	scaler_window_calc u_win (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_width(width), .i_height(height), .i_vset(vset), .i_hset(hset),
		.i_freescale(freescale), .i_arx(i_arx), .i_ary(i_ary),
		.i_arc1x(arc1x), .i_arc1y(arc1y), .i_arc2x(arc2x), .i_arc2y(arc2y),
		.o_out_w(o_out_w), .o_out_h(o_out_h),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax),
		.o_win_update(o_win_update)
	);

endmodule

// ==== source/scaler_window_calc.sv ====
`timescale 1ns/10ps
`include "vcfg_defines.svh"

module scaler_window_calc (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  vcfg_video_pkg::coord_t i_width,
	input  vcfg_video_pkg::coord_t i_height,
	input  vcfg_video_pkg::coord_t i_vset,
	input  vcfg_video_pkg::coord_t i_hset,
	input  logic                   i_freescale,
	input  vcfg_video_pkg::ar_t    i_arx,
	input  vcfg_video_pkg::ar_t    i_ary,
	input  vcfg_video_pkg::ar_t    i_arc1x,
	input  vcfg_video_pkg::ar_t    i_arc1y,
	input  vcfg_video_pkg::ar_t    i_arc2x,
	input  vcfg_video_pkg::ar_t    i_arc2y,
	output vcfg_video_pkg::coord_t o_out_w,
	output vcfg_video_pkg::coord_t o_out_h,
	output vcfg_video_pkg::coord_t o_hmin,
	output vcfg_video_pkg::coord_t o_hmax,
	output vcfg_video_pkg::coord_t o_vmin,
	output vcfg_video_pkg::coord_t o_vmax,
	output logic                   o_win_update
);

	vcfg_video_pkg::win_state_e state;
	vcfg_video_pkg::coord_t     arx;
	vcfg_video_pkg::coord_t     ary;
	logic                       direct;
	vcfg_video_pkg::coord_t     w;
	vcfg_video_pkg::coord_t     h;
	vcfg_video_pkg::coord_t     vid_w;
	vcfg_video_pkg::coord_t     vid_h;
	vcfg_video_pkg::coord_t     h_off;
	vcfg_video_pkg::coord_t     v_off;

	logic                       md_start;
	logic                       md_busy;
	vcfg_video_pkg::coord_t     md_mul1;
	vcfg_video_pkg::coord_t     md_mul2;
	vcfg_video_pkg::coord_t     md_div;
	vcfg_video_pkg::coord_t     md_result;

	umuldiv #(.WIDTH(`VCFG_COORD_W)) u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

	//////////////////////////////
	// Output size and ratio pick
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_out_w <= `VCFG_DEF_WIDTH;
			o_out_h <= `VCFG_DEF_HEIGHT;
			arx     <= '0;
			ary     <= '0;
			direct  <= 1'b0;
		end else begin
			o_out_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			o_out_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
			if (i_ary == '0) begin
				// ARX 1 and 2 point at the custom ratios
				if (i_arx == vcfg_video_pkg::ar_t'(1)) begin
					arx    <= i_arc1x[`VCFG_COORD_W-1:0];
					ary    <= i_arc1y[`VCFG_COORD_W-1:0];
					direct <= i_arc1x[`VCFG_AR_W-1] | i_arc1y[`VCFG_AR_W-1];
				end else if (i_arx == vcfg_video_pkg::ar_t'(2)) begin
					arx    <= i_arc2x[`VCFG_COORD_W-1:0];
					ary    <= i_arc2y[`VCFG_COORD_W-1:0];
					direct <= i_arc2x[`VCFG_AR_W-1] | i_arc2y[`VCFG_AR_W-1];
				end else begin
					arx    <= '0;
					ary    <= '0;
					direct <= 1'b0;
				end
			end else begin
				arx    <= i_arx[`VCFG_COORD_W-1:0];
				ary    <= i_ary[`VCFG_COORD_W-1:0];
				direct <= i_arx[`VCFG_AR_W-1] | i_ary[`VCFG_AR_W-1];
			end
		end
	end

	// Centring offsets
	assign h_off = (i_width - vid_w) >> 1;
	assign v_off = (i_height - vid_h) >> 1;

	//////////////////////////////
	// Window loop
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state        <= vcfg_video_pkg::WIN_SELECT;
			md_start     <= 1'b0;
			md_mul1      <= '0;
			md_mul2      <= '0;
			md_div       <= '0;
			w            <= '0;
			h            <= '0;
			vid_w        <= '0;
			vid_h        <= '0;
			o_hmin       <= '0;
			o_hmax       <= '0;
			o_vmin       <= '0;
			o_vmax       <= '0;
			o_win_update <= 1'b0;
		end else begin
			md_start     <= 1'b0;
			o_win_update <= 1'b0;
			case (state)
				vcfg_video_pkg::WIN_SELECT: begin
					if (i_freescale || arx == '0 || ary == '0) begin
						w     <= o_out_w;
						h     <= o_out_h;
						state <= vcfg_video_pkg::WIN_CLIP;
					end else if (direct) begin
						w     <= arx;
						h     <= ary;
						state <= vcfg_video_pkg::WIN_CLIP;
					end else begin
						state <= vcfg_video_pkg::WIN_W_START;
					end
				end
				vcfg_video_pkg::WIN_W_START: begin
					md_mul1  <= o_out_h;
					md_mul2  <= arx;
					md_div   <= ary;
					md_start <= 1'b1;
					state    <= vcfg_video_pkg::WIN_W_WAIT;
				end
				vcfg_video_pkg::WIN_W_WAIT: begin
					// Busy is not up yet in the cycle after start
					if (!(md_start || md_busy)) begin
						w     <= md_result;
						state <= vcfg_video_pkg::WIN_H_START;
					end
				end
				vcfg_video_pkg::WIN_H_START: begin
					md_mul1  <= o_out_w;
					md_mul2  <= ary;
					md_div   <= arx;
					md_start <= 1'b1;
					state    <= vcfg_video_pkg::WIN_H_WAIT;
				end
				vcfg_video_pkg::WIN_H_WAIT: begin
					if (!(md_start || md_busy)) begin
						h     <= md_result;
						state <= vcfg_video_pkg::WIN_SPARE;
					end
				end
				vcfg_video_pkg::WIN_SPARE: begin
					state <= vcfg_video_pkg::WIN_CLIP;
				end
				vcfg_video_pkg::WIN_CLIP: begin
					vid_w <= (w > o_out_w) ? o_out_w : w;
					vid_h <= (h > o_out_h) ? o_out_h : h;
					state <= vcfg_video_pkg::WIN_CENTER;
				end
				vcfg_video_pkg::WIN_CENTER: begin
					o_hmin       <= h_off;
					o_hmax       <= h_off + vid_w - 1'b1;
					o_vmin       <= v_off;
					o_vmax       <= v_off + vid_h - 1'b1;
					o_win_update <= 1'b1;
					state        <= vcfg_video_pkg::WIN_SELECT;
				end
				default: state <= vcfg_video_pkg::WIN_SELECT;
			endcase
		end
	end

endmodule

// ==== source/umuldiv.sv ====
`timescale 1ns/10ps

module umuldiv #(
	parameter int WIDTH = 12
) (
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  logic [WIDTH-1:0] i_mul1,
	input  logic [WIDTH-1:0] i_mul2,
	input  logic [WIDTH-1:0] i_div,
	output logic             o_busy,
	output logic [WIDTH-1:0] o_result
);

	localparam int CNT_W = $clog2(2 * WIDTH);

	logic               div_phase;
	logic [CNT_W-1:0]   cnt;
	logic [2*WIDTH-1:0] acc;
	logic [2*WIDTH-1:0] mcand;
	logic [WIDTH-1:0]   mplier;
	logic [WIDTH-1:0]   divisor;
	logic [WIDTH-1:0]   rem;
	logic [WIDTH:0]     rem_sh;
	logic [WIDTH:0]     diff;

	// Restoring step, top bit of diff is the borrow
	assign rem_sh = {rem, acc[2*WIDTH-1]};
	assign diff   = rem_sh - {1'b0, divisor};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy    <= 1'b0;
			div_phase <= 1'b0;
			cnt       <= '0;
		end else if (!o_busy) begin
			if (i_start) begin
				o_busy    <= 1'b1;
				div_phase <= 1'b0;
				cnt       <= '0;
			end
		end else begin
			cnt <= cnt + 1'b1;
			if (!div_phase && cnt == CNT_W'(WIDTH - 1)) begin
				div_phase <= 1'b1;
				cnt       <= '0;
			end else if (div_phase && cnt == CNT_W'(2 * WIDTH - 1)) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Shift-add product, then the product shifts out as the dividend
	always_ff @(posedge clk_sys) begin
		if (!o_busy) begin
			if (i_start) begin
				acc     <= '0;
				mcand   <= {{WIDTH{1'b0}}, i_mul1};
				mplier  <= i_mul2;
				divisor <= i_div;
				rem     <= '0;
			end
		end else if (!div_phase) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end else begin
			rem <= diff[WIDTH] ? rem_sh[WIDTH-1:0] : diff[WIDTH-1:0];
			acc <= {acc[2*WIDTH-2:0], ~diff[WIDTH]};
			if (cnt == CNT_W'(2 * WIDTH - 1))
				o_result <= {acc[WIDTH-2:0], ~diff[WIDTH]};
		end
	end

endmodule

// ==== source/host_cmd_regs.sv ====
`timescale 1ns/10ps
`include "vcfg_defines.svh"

module host_cmd_regs (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_uio,
	input  logic                   i_io_strobe,
	input  vcfg_io_pkg::io_word_t  i_io_din,
	output vcfg_video_pkg::coord_t o_width,
	output vcfg_video_pkg::coord_t o_height,
	output vcfg_video_pkg::coord_t o_vset,
	output vcfg_video_pkg::coord_t o_hset,
	output logic                   o_freescale,
	output vcfg_video_pkg::ar_t    o_arc1x,
	output vcfg_video_pkg::ar_t    o_arc1y,
	output vcfg_video_pkg::ar_t    o_arc2x,
	output vcfg_video_pkg::ar_t    o_arc2y,
	output vcfg_video_pkg::coord_t o_htotal,
	output vcfg_video_pkg::coord_t o_vtotal,
	output logic                   o_hs_neg,
	output logic                   o_vs_neg
);

	logic                      old_strobe;
	logic                      strobe_edge;
	logic                      has_cmd;
	logic [7:0]                cmd;
	vcfg_io_pkg::word_idx_t    cnt;

	vcfg_video_pkg::coord_t    width;
	vcfg_video_pkg::coord_t    hfp;
	vcfg_video_pkg::sync_len_t hs;
	vcfg_video_pkg::coord_t    hbp;
	vcfg_video_pkg::coord_t    height;
	vcfg_video_pkg::coord_t    vfp;
	vcfg_video_pkg::sync_len_t vs;
	vcfg_video_pkg::coord_t    vbp;

	assign strobe_edge = i_io_strobe & ~old_strobe;

	//////////////////////////////
	// Frame decode
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			old_strobe <= 1'b0;
			has_cmd    <= 1'b0;
			cmd        <= '0;
			cnt        <= '0;
		end else begin
			old_strobe <= i_io_strobe;
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
				cmd     <= '0;
			end else if (strobe_edge) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= i_io_din[7:0];
					cnt     <= '0;
				end else if (cnt != '1) begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Register writes
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			width       <= `VCFG_DEF_WIDTH;
			hfp         <= `VCFG_DEF_HFP;
			hs          <= {1'b0, `VCFG_DEF_HS};
			hbp         <= `VCFG_DEF_HBP;
			height      <= `VCFG_DEF_HEIGHT;
			vfp         <= `VCFG_DEF_VFP;
			vs          <= {1'b0, `VCFG_DEF_VS};
			vbp         <= `VCFG_DEF_VBP;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (i_io_uio && strobe_edge && has_cmd) begin
			case (cmd)
				vcfg_io_pkg::CMD_TIMING: begin
					// Words 8 and up are ignored
					if (!cnt[3]) begin
						case (cnt[2:0])
							3'd0: width  <= i_io_din[11:0];
							3'd1: hfp    <= i_io_din[11:0];
							3'd2: hs     <= {i_io_din[15], i_io_din[11:0]};
							3'd3: hbp    <= i_io_din[11:0];
							3'd4: height <= i_io_din[11:0];
							3'd5: vfp    <= i_io_din[11:0];
							3'd6: vs     <= {i_io_din[15], i_io_din[11:0]};
							3'd7: vbp    <= i_io_din[11:0];
						endcase
					end
				end
				vcfg_io_pkg::CMD_VSET: begin
					if (cnt == '0)
						o_vset <= i_io_din[11:0];
				end
				vcfg_io_pkg::CMD_HSET: begin
					if (cnt == '0) begin
						o_freescale <= i_io_din[15];
						o_hset      <= i_io_din[11:0];
					end
				end
				vcfg_io_pkg::CMD_ARC: begin
					case (cnt)
						4'd0: o_arc1x <= i_io_din[12:0];
						4'd1: o_arc1y <= i_io_din[12:0];
						4'd2: o_arc2x <= i_io_din[12:0];
						4'd3: o_arc2y <= i_io_din[12:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Totals follow the registers one cycle later
	always_ff @(posedge clk_sys) begin
		o_htotal <= width + hfp + hbp + hs[11:0];
		o_vtotal <= height + vfp + vbp + vs[11:0];
		o_hs_neg <= hs[12];
		o_vs_neg <= vs[12];
	end

	assign o_width  = width;
	assign o_height = height;

endmodule

// ==== source/vcfg_video_pkg.sv ====
`include "vcfg_defines.svh"

package vcfg_video_pkg;

	// Pixel or line count
	typedef logic [`VCFG_COORD_W-1:0] coord_t;

	// Aspect field, top bit means direct size
	typedef logic [`VCFG_AR_W-1:0] ar_t;

	// Sync length with negative polarity in the top bit
	typedef logic [`VCFG_COORD_W:0] sync_len_t;

	// Window calculation loop
	typedef enum logic [2:0] {
		WIN_SELECT  = 3'd0,
		WIN_W_START = 3'd1,
		WIN_W_WAIT  = 3'd2,
		WIN_H_START = 3'd3,
		WIN_H_WAIT  = 3'd4,
		WIN_SPARE   = 3'd5,
		WIN_CLIP    = 3'd6,
		WIN_CENTER  = 3'd7
	} win_state_e;

endpackage

// ==== source/vcfg_io_pkg.sv ====
`include "vcfg_defines.svh"

package vcfg_io_pkg;

	// One word as written by the host
	typedef logic [`VCFG_IO_W-1:0] io_word_t;

	// Commands handled by the register block
	typedef enum logic [7:0] {
		CMD_TIMING = `VCFG_CMD_TIMING,
		CMD_VSET   = `VCFG_CMD_VSET,
		CMD_HSET   = `VCFG_CMD_HSET,
		CMD_ARC    = `VCFG_CMD_ARC
	} io_cmd_e;

	// Data word position inside a frame, saturates at 15
	typedef logic [3:0] word_idx_t;

endpackage

// ==== source/vcfg_defines.svh ====
`ifndef VCFG_DEFINES_SVH
`define VCFG_DEFINES_SVH

// Bus and field widths
`define VCFG_IO_W       16
`define VCFG_COORD_W    12
`define VCFG_AR_W       13

// 1920x1080 timing after reset
`define VCFG_DEF_WIDTH  12'd1920
`define VCFG_DEF_HFP    12'd88
`define VCFG_DEF_HS     12'd48
`define VCFG_DEF_HBP    12'd148

`define VCFG_DEF_HEIGHT 12'd1080
`define VCFG_DEF_VFP    12'd4
`define VCFG_DEF_VS     12'd5
`define VCFG_DEF_VBP    12'd36

//////////////////////////////
// Host command codes
//////////////////////////////
`define VCFG_CMD_TIMING 8'h20
`define VCFG_CMD_VSET   8'h27
`define VCFG_CMD_HSET   8'h37
`define VCFG_CMD_ARC    8'h3A

`endif
